// File: testbench/tank_trace.txt
# cnt bx1 by1 bx2 by2 xt1 yt1 xt2 yt2 x y red_ack green_ack restart (count decimal, rest hex)
# then expected three cycles after the row: player_screen pixel explosion_flag des_bullet1 des_bullet2
4 000 000 000 000 064 064 078 064 000 000 0 0 0 0 000 0 0 0
1 000 000 000 000 064 064 078 064 064 064 0 0 0 0 F00 0 0 0
1 000 000 000 000 064 064 078 064 083 083 0 0 0 0 F00 0 0 0
1 000 000 000 000 064 064 078 064 064 084 0 0 0 0 000 0 0 0
1 000 000 000 000 064 064 078 064 097 083 0 0 0 0 0F0 0 0 0
1 000 000 000 000 064 064 078 064 098 064 0 0 0 0 000 0 0 0
2 000 000 070 070 064 064 078 064 000 000 0 0 0 0 000 0 0 1
1 000 000 070 070 064 064 078 064 070 070 0 0 0 0 FA0 0 0 1
15 000 000 070 070 064 064 078 064 070 070 0 0 0 0 FA0 0 0 0
1 000 000 070 070 064 064 078 064 000 000 0 0 0 0 000 1 0 0
3 000 000 070 070 064 064 078 064 000 000 1 0 0 0 000 0 0 0
2 090 070 000 000 064 064 078 064 000 000 0 0 0 0 000 0 1 0
16 090 070 000 000 064 064 078 064 090 070 0 0 0 0 FA0 0 0 0
2 090 070 000 000 064 064 078 064 000 000 0 0 0 0 000 1 1 0
16 090 070 000 000 064 064 078 064 090 070 0 0 0 0 FA0 1 0 0
2 090 070 000 000 064 064 078 064 000 000 0 0 0 0 000 1 1 0
16 090 070 000 000 064 064 078 064 090 070 0 0 0 0 FA0 1 0 0
2 090 070 000 000 064 064 078 064 000 000 0 0 0 2 000 1 0 0
4 090 070 000 000 064 064 078 064 000 000 0 0 0 0 000 1 0 0
2 090 070 000 000 064 064 078 064 000 000 0 0 1 0 000 1 0 0
4 000 000 000 000 064 064 078 064 000 000 0 0 0 0 000 1 0 0
-1 000 000 000 000 000 000 000 000 000 000 0 0 0 0 000 0 0 0

// File: tb.f
+incdir+rtl
rtl/tank_pkg.sv
rtl/scan_if.sv
rtl/layer_if.sv
rtl/scan_router.sv
rtl/player_unit.sv
rtl/screen_arbiter.sv
rtl/tank_controller.sv
testbench/tb_assert.sv
testbench/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the tank controller testbench with Verilator
set -e

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o sim_tb

# a fatal stop returns nonzero, the log decides the verdict
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// File: testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top
	import tank_pkg::*;
();

	typedef struct packed {
		int due;
		logic [4:0][11:0] exp_val;
	} expect_t;

	logic clk25;
	logic reset;
	x_coord_t bullet_x1, bullet_x2, x_tank1, x_tank2, x;
	y_coord_t bullet_y1, bullet_y2, y_tank1, y_tank2, y;
	logic red_explosion_ack, green_explosion_ack, reset_plyrScrn;
	screen_e player_screen;
	pixel_t first_screen_out;
	logic explosion_flag, des_bullet1, des_bullet2;
	int edge_count;
	expect_t exp_q [$];

	tank_controller #(
		.EXPLOSION_LEN(16)
	) UUT (
		.clk25(clk25), .reset(reset),
		.bullet_x1(bullet_x1), .bullet_x2(bullet_x2),
		.x_tank1(x_tank1), .x_tank2(x_tank2), .x(x),
		.bullet_y1(bullet_y1), .bullet_y2(bullet_y2),
		.y_tank1(y_tank1), .y_tank2(y_tank2), .y(y),
		.red_explosion_ack(red_explosion_ack),
		.green_explosion_ack(green_explosion_ack),
		.reset_plyrScrn(reset_plyrScrn),
		.player_screen(player_screen), .first_screen_out(first_screen_out),
		.explosion_flag(explosion_flag),
		.des_bullet1(des_bullet1), .des_bullet2(des_bullet2)
	);

	initial
	begin
		clk25 = 1'b0;
		forever #20 clk25 = ~clk25;   // 25 MHz
	end

	always @(posedge clk25)
		edge_count <= edge_count + 1;

	task automatic check_value(input string name, input logic [11:0] got,
		input logic [11:0] expected);
		if (got !== expected)
		begin
			$display("Error: %s is %h, expected %h", name, got, expected);
			$display("Errors found");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic compare_outputs(input logic [4:0][11:0] ev);
		check_value("player_screen", 12'(player_screen), ev[0]);
		check_value("first_screen_out", first_screen_out, ev[1]);
		check_value("explosion_flag", 12'(explosion_flag), ev[2]);
		check_value("des_bullet1", 12'(des_bullet1), ev[3]);
		check_value("des_bullet2", 12'(des_bullet2), ev[4]);
	endtask

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk25)
	begin : check_due
		expect_t e;
		if (exp_q.size() > 0)
		begin
			e = exp_q[0];
			if (edge_count > e.due)
			begin
				$display("a scheduled output check was missed");
				$display("Errors found");
				$fatal(1, "check schedule broken");
			end
			else if (edge_count == e.due)
			begin
				void'(exp_q.pop_front());
				compare_outputs(e.exp_val);
			end
		end
	end

	initial
	begin : main
		int fd;
		int rc;
		int cnt;
		int waited;
		int unsigned col [18];
		string line;
		expect_t e;
		logic [4:0][11:0] reset_vals;
		bit done;
		edge_count = 0;
		done = 0;
		reset <= 1'b1;
		bullet_x1 <= '0;
		bullet_x2 <= '0;
		bullet_y1 <= '0;
		bullet_y2 <= '0;
		x_tank1 <= '0;
		x_tank2 <= '0;
		y_tank1 <= '0;
		y_tank2 <= '0;
		x <= '0;
		y <= '0;
		red_explosion_ack <= 1'b0;
		green_explosion_ack <= 1'b0;
		reset_plyrScrn <= 1'b0;
		fd = $fopen("testbench/tank_trace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the trace file");
			$display("Errors found");
			$fatal(1, "no stimulus");
		end
		repeat (9) @(posedge clk25);
		reset_vals = '{12'h0, 12'h000, 12'h0, 12'h0, 12'h0};
		@(negedge clk25);
		compare_outputs(reset_vals);    // values held by reset
		while (!done && !$feof(fd))
		begin
			rc = $fgets(line, fd);
			if (rc == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			rc = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				cnt, col[0], col[1], col[2], col[3], col[4], col[5],
				col[6], col[7], col[8], col[9], col[10], col[11],
				col[12], col[13], col[14], col[15], col[16], col[17]);
			if (rc != 19)
			begin
				$display("a trace row could not be read");
				$display("Errors found");
				$fatal(1, "bad trace row");
			end
			if (cnt < 0)
			begin
				done = 1;
				continue;
			end
			@(posedge clk25);
			reset <= 1'b0;                 // first row leaves reset
			bullet_x1 <= x_coord_t'(col[0]);
			bullet_y1 <= y_coord_t'(col[1]);
			bullet_x2 <= x_coord_t'(col[2]);
			bullet_y2 <= y_coord_t'(col[3]);
			x_tank1 <= x_coord_t'(col[4]);
			y_tank1 <= y_coord_t'(col[5]);
			x_tank2 <= x_coord_t'(col[6]);
			y_tank2 <= y_coord_t'(col[7]);
			x <= x_coord_t'(col[8]);
			y <= y_coord_t'(col[9]);
			red_explosion_ack <= col[10][0];
			green_explosion_ack <= col[11][0];
			reset_plyrScrn <= col[12][0];
			e.due = edge_count + cnt + 3;   // three stages behind the last cycle
			for (int i = 0; i < 5; i++)
				e.exp_val[i] = 12'(col[13 + i]);
			exp_q.push_back(e);
			repeat (cnt - 1) @(posedge clk25);
		end
		$fclose(fd);
		waited = 0;
		while (exp_q.size() > 0 && waited < 100)
		begin
			@(posedge clk25);
			waited++;
		end
		if (exp_q.size() > 0)
		begin
			$display("timed out waiting for the last output checks");
			$display("Errors found");
			$fatal(1, "run did not complete");
		end
		else
		begin
			$display("No errors");
			$finish;
		end
	end

endmodule

// File: testbench/tb_assert.sv
`timescale 1ns/1ps

module tb_assert
	import tank_pkg::*;
(
	input logic clk25,
	input logic reset,
	input screen_e player_screen,
	input logic explosion_flag,
	input logic des_bullet1,
	input logic des_bullet2
);

	// leaving the play screen is only allowed towards a winner
	assert property (@(posedge clk25) disable iff (reset)
		($past(player_screen) == screen_play && player_screen != screen_play) |->
		(player_screen == screen_red_wins || player_screen == screen_green_wins))
	else $error("player_screen left play into an unknown code");

	assert property (@(posedge clk25) disable iff (reset)
		$rose(explosion_flag) |-> !(des_bullet1 && des_bullet2))
	else $error("both bullets destroyed while explosion_flag rose");

	assert property (@(posedge clk25) (reset && $past(reset)) |-> !explosion_flag)
	else $error("explosion_flag high during reset");

endmodule

bind tank_controller tb_assert u_assert (
	.clk25(clk25),
	.reset(reset),
	.player_screen(player_screen),
	.explosion_flag(explosion_flag),
	.des_bullet1(des_bullet1),
	.des_bullet2(des_bullet2)
);

// File: rtl/tank_controller.sv
`timescale 1ns/1ps
`include "tank_macros.svh"

module tank_controller
	import tank_pkg::*;
#(
	parameter int EXPLOSION_LEN = `EXPLOSION_CYCLES
)
(
	input logic clk25,
	input logic reset,
	input x_coord_t bullet_x1,
	input x_coord_t bullet_x2,
	input x_coord_t x_tank1,
	input x_coord_t x_tank2,
	input x_coord_t x,
	input y_coord_t bullet_y1,
	input y_coord_t bullet_y2,
	input y_coord_t y_tank1,
	input y_coord_t y_tank2,
	input y_coord_t y,
	input logic red_explosion_ack,
	input logic green_explosion_ack,
	input logic reset_plyrScrn,
	output screen_e player_screen,
	output pixel_t first_screen_out,
	output logic explosion_flag,
	output logic des_bullet1,
	output logic des_bullet2
);

	// index 0 red, index 1 green
	scan_if scan_bus [2] ();
	layer_if layer_bus [2] ();

	scan_router u_router (
		.clk25(clk25),
		.reset(reset),
		.bullet_x1(bullet_x1),
		.bullet_y1(bullet_y1),
		.bullet_x2(bullet_x2),
		.bullet_y2(bullet_y2),
		.x_tank1(x_tank1),
		.y_tank1(y_tank1),
		.x_tank2(x_tank2),
		.y_tank2(y_tank2),
		.x(x),
		.y(y),
		.reset_plyrScrn(reset_plyrScrn),
		.red_scan(scan_bus[0]),
		.green_scan(scan_bus[1])
	);

	for (genvar i = 0; i < 2; i++)
	begin : g_unit
		player_unit #(
			.EXPLOSION_LEN(EXPLOSION_LEN)
		) u_unit (
			.clk25(clk25),
			.reset(reset),
			.scan(scan_bus[i]),
			.layer(layer_bus[i])
		);
	end

	screen_arbiter u_arbiter (
		.clk25(clk25),
		.reset(reset),
		.red_layer(layer_bus[0]),
		.green_layer(layer_bus[1]),
		.red_explosion_ack(red_explosion_ack),
		.green_explosion_ack(green_explosion_ack),
		.restart(reset_plyrScrn),
		.first_screen_out(first_screen_out),
		.explosion_flag(explosion_flag),
		.player_screen(player_screen),
		.des_bullet1(des_bullet1),
		.des_bullet2(des_bullet2)
	);

endmodule

// File: rtl/screen_arbiter.sv
`timescale 1ns/1ps
`include "tank_macros.svh"

module screen_arbiter
	import tank_pkg::*;
(
	input logic clk25,
	input logic reset,
	layer_if.arbiter red_layer,
	layer_if.arbiter green_layer,
	input logic red_explosion_ack,
	input logic green_explosion_ack,
	input logic restart,
	output pixel_t first_screen_out,
	output logic explosion_flag,
	output screen_e player_screen,
	output logic des_bullet1,
	output logic des_bullet2
);

	pixel_t pixel_next;

	always_comb
	begin
		if (red_layer.boom_on || green_layer.boom_on)
			pixel_next = `BOOM_COLOR;
		else if (red_layer.tank_on)
			pixel_next = `RED_COLOR;     // red on top where boxes overlap
		else if (green_layer.tank_on)
			pixel_next = `GREEN_COLOR;
		else
			pixel_next = `BG_COLOR;
	end

	always_ff @(posedge clk25)
	begin
		if (reset)
			first_screen_out <= `BG_COLOR;
		else
			first_screen_out <= pixel_next;
	end

	// tells the movement logic to put the tanks back
	always_ff @(posedge clk25)
	begin
		if (reset)
			explosion_flag <= 1'b0;
		else if (red_layer.scored || green_layer.scored)
			explosion_flag <= 1'b1;
		else if (red_explosion_ack || green_explosion_ack)
			explosion_flag <= 1'b0;
	end

	// a unit's score counts hits taken, so the other colour wins
	always_ff @(posedge clk25)
	begin
		if (reset)
			player_screen <= screen_play;
		else if (green_layer.won)
			player_screen <= screen_red_wins;
		else if (red_layer.won)
			player_screen <= screen_green_wins;
		else if (restart)
			player_screen <= screen_play;
	end

	assign des_bullet1 = green_layer.destroyed;   // red bullet gone
	assign des_bullet2 = red_layer.destroyed;     // green bullet gone

endmodule

// File: rtl/player_unit.sv
`timescale 1ns/1ps
`include "tank_macros.svh"

module player_unit
	import tank_pkg::*;
#(
	parameter int EXPLOSION_LEN = `EXPLOSION_CYCLES
)
(
	input logic clk25,
	input logic reset,
	scan_if.unit scan,
	layer_if.unit layer
);

	logic [10:0] x_hi;    // far edge, spare bit for the 1023 corner
	logic [9:0] y_hi;
	logic scan_valid;     // router holds real data one cycle after reset
	logic beam_in;
	logic hit;
	unit_state_e state;
	boom_count_t count;
	score_t score;        // times this tank was destroyed

	assign x_hi = {1'b0, scan.tank_x} + 11'(`TANK_SIZE - 1);
	assign y_hi = {1'b0, scan.tank_y} + 10'(`TANK_SIZE - 1);

	assign beam_in = scan_valid &&
		(scan.beam_x >= scan.tank_x) && ({1'b0, scan.beam_x} <= x_hi) &&
		(scan.beam_y >= scan.tank_y) && ({1'b0, scan.beam_y} <= y_hi);

	// a hit only counts while the beam is over the tank
	assign hit = beam_in &&
		(scan.shot_x >= scan.tank_x) && ({1'b0, scan.shot_x} <= x_hi) &&
		(scan.shot_y >= scan.tank_y) && ({1'b0, scan.shot_y} <= y_hi);

	always_ff @(posedge clk25)
	begin
		if (reset)
		begin
			state <= alive;
			count <= '0;
			score <= '0;
			layer.destroyed <= 1'b0;
			layer.scored <= 1'b0;
			layer.won <= 1'b0;
		end
		else
		begin
			layer.scored <= 1'b0;   // pulses by default
			layer.won <= 1'b0;
			if (hit)
			begin
				count <= count + 17'd1;
				state <= exploding;
				layer.destroyed <= 1'b1;
			end
			else if (state == exploding && count == boom_count_t'(EXPLOSION_LEN))
			begin
				count <= '0;
				score <= score + 2'd1;
				layer.scored <= 1'b1;
				layer.destroyed <= 1'b0;
				state <= alive;
			end
			else if (score == score_t'(`WIN_SCORE))
			begin
				layer.won <= 1'b1;
				score <= '0;
			end
			else if (scan.restart)
			begin
				score <= '0;
			end
		end
	end

	// second pipeline stage of the pixel path
	always_ff @(posedge clk25)
	begin
		if (reset)
		begin
			scan_valid <= 1'b0;
			layer.tank_on <= 1'b0;
			layer.boom_on <= 1'b0;
		end
		else
		begin
			scan_valid <= 1'b1;
			layer.tank_on <= beam_in;
			layer.boom_on <= hit;
		end
	end

endmodule

// File: rtl/scan_router.sv
`timescale 1ns/1ps

module scan_router
	import tank_pkg::*;
(
	input logic clk25,
	input logic reset,
	input x_coord_t bullet_x1,
	input y_coord_t bullet_y1,
	input x_coord_t bullet_x2,
	input y_coord_t bullet_y2,
	input x_coord_t x_tank1,
	input y_coord_t y_tank1,
	input x_coord_t x_tank2,
	input y_coord_t y_tank2,
	input x_coord_t x,
	input y_coord_t y,
	input logic reset_plyrScrn,
	scan_if.router red_scan,
	scan_if.router green_scan
);

	always_ff @(posedge clk25)
	begin
		if (reset)
		begin
			red_scan.beam_x <= '0;
			red_scan.beam_y <= '0;
			red_scan.tank_x <= '0;
			red_scan.tank_y <= '0;
			red_scan.shot_x <= '0;
			red_scan.shot_y <= '0;
			red_scan.restart <= 1'b0;
			green_scan.beam_x <= '0;
			green_scan.beam_y <= '0;
			green_scan.tank_x <= '0;
			green_scan.tank_y <= '0;
			green_scan.shot_x <= '0;
			green_scan.shot_y <= '0;
			green_scan.restart <= 1'b0;
		end
		else
		begin
			red_scan.beam_x <= x;             // same beam for both
			red_scan.beam_y <= y;
			red_scan.tank_x <= x_tank1;
			red_scan.tank_y <= y_tank1;
			red_scan.shot_x <= bullet_x2;     // red is shot by green
			red_scan.shot_y <= bullet_y2;
			red_scan.restart <= reset_plyrScrn;
			green_scan.beam_x <= x;
			green_scan.beam_y <= y;
			green_scan.tank_x <= x_tank2;
			green_scan.tank_y <= y_tank2;
			green_scan.shot_x <= bullet_x1;   // green is shot by red
			green_scan.shot_y <= bullet_y1;
			green_scan.restart <= reset_plyrScrn;
		end
	end

endmodule

// File: rtl/layer_if.sv
`timescale 1ns/1ps

interface layer_if
	import tank_pkg::*;
();

	logic tank_on;      // beam inside the tank box
	logic boom_on;      // explosion pixel
	logic destroyed;    // opponent bullet must go away
	logic scored;       // one cycle at end of explosion
	logic won;          // one cycle when score hits the limit

	// pixel_t is carried by the arbiter, the layer only flags coverage

	modport unit (
		output tank_on, boom_on, destroyed, scored, won
	);

	modport arbiter (
		input tank_on, boom_on, destroyed, scored, won
	);

endinterface

// File: rtl/scan_if.sv
`timescale 1ns/1ps

interface scan_if
	import tank_pkg::*;
();

	x_coord_t beam_x;
	y_coord_t beam_y;
	x_coord_t tank_x;    // this player's tank corner
	y_coord_t tank_y;
	x_coord_t shot_x;    // opponent bullet
	y_coord_t shot_y;
	logic restart;

	modport router (
		output beam_x, beam_y, tank_x, tank_y, shot_x, shot_y, restart
	);

	modport unit (
		input beam_x, beam_y, tank_x, tank_y, shot_x, shot_y, restart
	);

endinterface

// File: rtl/tank_pkg.sv
package tank_pkg;

	typedef logic [9:0] x_coord_t;    // 0..639 visible
	typedef logic [8:0] y_coord_t;    // 0..479 visible
	typedef logic [11:0] pixel_t;     // 4:4:4 rgb
	typedef logic [1:0] score_t;
	typedef logic [16:0] boom_count_t;

	// encoding seen by the screen switch logic
	typedef enum logic [1:0] {
		screen_play       = 2'd0,
		screen_green_wins = 2'd1,
		screen_red_wins   = 2'd2
	} screen_e;

	typedef enum logic {
		alive,
		exploding
	} unit_state_e;

endpackage

// File: rtl/tank_macros.svh
`ifndef TANK_MACROS_SVH
`define TANK_MACROS_SVH

// tank box edge in pixels
`define TANK_SIZE 32

// explosion length in counted hit cycles
`define EXPLOSION_CYCLES 60000

// points needed to win
`define WIN_SCORE 3

`define RED_COLOR   12'hF00
`define GREEN_COLOR 12'h0F0
`define BOOM_COLOR  12'hFA0   // orange fireball
`define BG_COLOR    12'h000

`endif
